// File: verilog/fpu_op_pkg.sv
package fpu_op_pkg;

	////////////////////////////////////////////////////////////
	// operation codes
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		OP_ADD_D = 2'b00,	// double add/sub
		OP_ADD_S = 2'b01,	// single add/sub
		OP_STOD  = 2'b10,	// single to double
		OP_DTOS  = 2'b11	// double to single
	} op_t;

	typedef enum logic {
		PREC_D = 1'b0,
		PREC_S = 1'b1
	} prec_t;

	// per stage control, valid plus opcode
	typedef struct packed {
		logic valid;
		op_t  op;
	} stage_ctl_t;

	// opcodes the pipe knows how to run
	function automatic logic op_legal(op_t op);
		case (op)
			OP_ADD_D, OP_ADD_S, OP_STOD, OP_DTOS: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic is_addsub(op_t op);
		return (op == OP_ADD_D) || (op == OP_ADD_S);
	endfunction

	// precision of the operands coming in
	function automatic prec_t src_prec(op_t op);
		return ((op == OP_ADD_S) || (op == OP_STOD)) ? PREC_S : PREC_D;
	endfunction

	// precision of the result going out
	function automatic prec_t dst_prec(op_t op);
		return ((op == OP_ADD_S) || (op == OP_DTOS)) ? PREC_S : PREC_D;
	endfunction

endpackage

// File: verilog/fpu_exp_pkg.sv
package fpu_exp_pkg;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////

	localparam int EXP_W  = 11;	// ieee double exponent field
	localparam int WEXP_W = 13;	// signed working width, room for under/overflow
	localparam int DIFF_W = 12;	// alignment difference
	localparam int SNG_W  = 8;	// single exponent, bits 7:0 of the field

	typedef logic [EXP_W-1:0]         exp_field_t;
	typedef logic signed [WEXP_W-1:0] wexp_t;

	////////////////////////////////////////////////////////////
	// biases and limits
	////////////////////////////////////////////////////////////

	// single exponent lives in the low bits
	localparam exp_field_t SNG_MASK = exp_field_t'((1 << SNG_W) - 1);

	localparam wexp_t EXP_ZERO    = wexp_t'(0);
	localparam wexp_t DBL_MAX_EXP = wexp_t'(2047);	// double inf/nan exponent
	localparam wexp_t SNG_MAX_EXP = wexp_t'(255);	// single inf/nan exponent

	// 1023 - 127
	localparam wexp_t CVT_BIAS = wexp_t'(896);

	////////////////////////////////////////////////////////////
	// stage payloads
	////////////////////////////////////////////////////////////

	// stage 1 -> stage 2
	typedef struct packed {
		logic              swap;	// b operand is larger
		logic [DIFF_W-1:0] diff;	// |a - b| for fraction align
		wexp_t             exp;		// larger exp, or b for converts
	} align_t;

endpackage

// File: verilog/fpu_add_exp_ctl.sv
`timescale 1ns/1ps

module fpu_add_exp_ctl (
	input  logic                   rclk,
	input  logic                   i_reset,
	input  logic                   i_valid,	// one pulse per op
	input  fpu_op_pkg::op_t        i_op,
	output fpu_op_pkg::stage_ctl_t o_s1_ctl,	// to compare stage
	output fpu_op_pkg::stage_ctl_t o_s2_ctl,	// to rebias stage
	output fpu_op_pkg::stage_ctl_t o_s3_ctl,	// to normalize stage
	output logic                   o_align_valid,
	output logic                   o_valid
);

	import fpu_op_pkg::*;

	stage_ctl_t s0_ctl;	// decoded at the pipe input
	stage_ctl_t s1_ctl;
	stage_ctl_t s2_ctl;
	stage_ctl_t s3_ctl;
	logic       out_valid;

	////////////////////////////////////////////////////////////
	// input decode
	////////////////////////////////////////////////////////////

	// idle or unknown opcode goes down the pipe as a bubble
	always_comb begin
		s0_ctl = '0;
		if (i_valid && op_legal(i_op)) begin
			s0_ctl.valid = 1'b1;
			s0_ctl.op    = i_op;
		end
	end

	////////////////////////////////////////////////////////////
	// control pipe
	////////////////////////////////////////////////////////////

	// no stall, every stage advances each cycle
	always_ff @(posedge rclk) begin
		if (i_reset) begin
			s1_ctl    <= '0;
			s2_ctl    <= '0;
			s3_ctl    <= '0;
			out_valid <= 1'b0;
		end else begin
			s1_ctl    <= s0_ctl;	// lines up with operand capture
			s2_ctl    <= s1_ctl;	// lines up with align payload
			s3_ctl    <= s2_ctl;	// lines up with rebiased exp
			out_valid <= s3_ctl.valid;	// lines up with o_exp
		end
	end

	assign o_s1_ctl = s1_ctl;
	assign o_s2_ctl = s2_ctl;
	assign o_s3_ctl = s3_ctl;

	// swap/diff go out one cycle after issue
	assign o_align_valid = s2_ctl.valid;

	// result exponent three cycles after issue
	assign o_valid = out_valid;

endmodule

// File: verilog/fpu_exp_cmp.sv
`timescale 1ns/1ps

module fpu_exp_cmp (
	input  logic                   rclk,
	input  fpu_exp_pkg::exp_field_t i_exp_a,
	input  fpu_exp_pkg::exp_field_t i_exp_b,
	input  fpu_op_pkg::stage_ctl_t i_s1_ctl,
	output fpu_exp_pkg::align_t    o_align
);

	import fpu_op_pkg::*;
	import fpu_exp_pkg::*;

	exp_field_t a_q;	// raw operand exponents
	exp_field_t b_q;
	exp_field_t a_m;	// masked to format
	exp_field_t b_m;
	wexp_t      a_w;
	wexp_t      b_w;
	wexp_t      sub_ab;	// a - b
	wexp_t      sub_ba;	// b - a
	logic       b_gt_a;
	align_t     align_d;

	////////////////////////////////////////////////////////////
	// operand capture
	////////////////////////////////////////////////////////////

	// op for this cycle arrives on i_s1_ctl next to the data
	always_ff @(posedge rclk) begin
		a_q <= i_exp_a;
		b_q <= i_exp_b;
	end

	// single keeps bits 7:0 only
	assign a_m = (src_prec(i_s1_ctl.op) == PREC_S) ? (a_q & SNG_MASK) : a_q;
	assign b_m = (src_prec(i_s1_ctl.op) == PREC_S) ? (b_q & SNG_MASK) : b_q;

	assign a_w = wexp_t'({2'b00, a_m});	// zero extend, always positive
	assign b_w = wexp_t'({2'b00, b_m});

	////////////////////////////////////////////////////////////
	// compare
	////////////////////////////////////////////////////////////

	assign sub_ab = a_w + ~b_w + wexp_t'(1);	// a + ~b + cin
	assign sub_ba = b_w - a_w;
	assign b_gt_a = sub_ab[WEXP_W-1];	// sign of a - b

	always_comb begin
		align_d = '0;
		if (is_addsub(i_s1_ctl.op)) begin
			align_d.swap = b_gt_a;
			align_d.diff = b_gt_a ? sub_ba[DIFF_W-1:0] : sub_ab[DIFF_W-1:0];
			align_d.exp  = b_gt_a ? b_w : a_w;	// larger one carries on
		end else begin
			align_d.exp = b_w;	// converts use operand 2 only
		end
	end

	// hold last item through bubbles
	always_ff @(posedge rclk) begin
		if (i_s1_ctl.valid) begin
			o_align <= align_d;
		end
	end

endmodule

// File: verilog/fpu_exp_adj.sv
`timescale 1ns/1ps

module fpu_exp_adj (
	input  logic                   rclk,
	input  fpu_exp_pkg::align_t    i_align,
	input  fpu_op_pkg::stage_ctl_t i_s2_ctl,
	output fpu_exp_pkg::wexp_t     o_exp
);

	import fpu_op_pkg::*;
	import fpu_exp_pkg::*;

	wexp_t e_up;	// single -> double
	wexp_t e_dn;	// double -> single, before clamp
	wexp_t e_dn_clamp;
	wexp_t e_next;

	////////////////////////////////////////////////////////////
	// conversion rebias
	////////////////////////////////////////////////////////////

	assign e_up = i_align.exp + CVT_BIAS;
	assign e_dn = i_align.exp - CVT_BIAS;

	// too small for single flushes, too large goes to inf
	always_comb begin
		if (e_dn <= EXP_ZERO) begin
			e_dn_clamp = EXP_ZERO;
		end else if (e_dn >= SNG_MAX_EXP) begin
			e_dn_clamp = SNG_MAX_EXP;
		end else begin
			e_dn_clamp = e_dn;
		end
	end

	always_comb begin
		case (i_s2_ctl.op)
			OP_STOD: e_next = e_up;
			OP_DTOS: e_next = e_dn_clamp;
			default: e_next = i_align.exp;	// add/sub passes through
		endcase
	end

	always_ff @(posedge rclk) begin
		if (i_s2_ctl.valid) begin
			o_exp <= e_next;
		end
	end

endmodule

// File: verilog/fpu_exp_norm.sv
`timescale 1ns/1ps

module fpu_exp_norm #(
	parameter int SHL_W = 6	// post-norm shift count width
) (
	input  logic                   rclk,
	input  logic                   i_reset,
	input  fpu_exp_pkg::wexp_t     i_exp,
	input  fpu_op_pkg::stage_ctl_t i_s3_ctl,
	input  logic                   i_norm_inc,	// fraction carried out
	input  logic [SHL_W-1:0]       i_shl_cnt,	// leading zeros shifted out
	input  logic                   i_round_cout,	// rounding carried out
	output fpu_exp_pkg::exp_field_t o_exp
);

	import fpu_op_pkg::*;
	import fpu_exp_pkg::*;

	localparam int PAD_W = WEXP_W - SHL_W;

	wexp_t shl_ext;
	wexp_t e_pn;	// post-norm, add/sub only
	wexp_t e_pn_fl;	// flushed
	wexp_t e_sel;
	wexp_t e_rnd;
	wexp_t fmt_max;
	wexp_t e_sat;

	////////////////////////////////////////////////////////////
	// post-normalization
	////////////////////////////////////////////////////////////

	assign shl_ext = wexp_t'({{PAD_W{1'b0}}, i_shl_cnt});

	// carry out wins over a left shift
	assign e_pn = i_norm_inc ? (i_exp + wexp_t'(1)) : (i_exp - shl_ext);

	assign e_pn_fl = (e_pn <= EXP_ZERO) ? EXP_ZERO : e_pn;	// denorm result

	// converts were already fixed up in stage 2
	assign e_sel = is_addsub(i_s3_ctl.op) ? e_pn_fl : i_exp;

	////////////////////////////////////////////////////////////
	// rounding and overflow
	////////////////////////////////////////////////////////////

	assign e_rnd = i_round_cout ? (e_sel + wexp_t'(1)) : e_sel;

	assign fmt_max = (dst_prec(i_s3_ctl.op) == PREC_S) ? SNG_MAX_EXP : DBL_MAX_EXP;

	// overflow always lands on infinity
	assign e_sat = (e_rnd >= fmt_max) ? fmt_max : e_rnd;

	always_ff @(posedge rclk) begin
		if (i_reset) begin
			o_exp <= '0;
		end else if (i_s3_ctl.valid) begin
			o_exp <= e_sat[EXP_W-1:0];	// always positive here
		end
	end

endmodule

// File: verilog/fpu_add_exp.sv
`timescale 1ns/1ps

module fpu_add_exp #(
	parameter int SHL_W = 6
) (
	input  logic                                rclk,
	input  logic                                i_reset,
	input  logic                                i_valid,
	input  fpu_op_pkg::op_t                     i_op,
	input  fpu_exp_pkg::exp_field_t             i_exp_a,
	input  fpu_exp_pkg::exp_field_t             i_exp_b,
	input  logic                                i_norm_inc,	// from fraction path
	input  logic [SHL_W-1:0]                    i_shl_cnt,
	input  logic                                i_round_cout,
	output logic                                o_align_valid,
	output logic                                o_swap,
	output logic [fpu_exp_pkg::DIFF_W-1:0]      o_exp_diff,	// to fraction aligner
	output logic                                o_valid,
	output fpu_exp_pkg::exp_field_t             o_exp
);

	import fpu_op_pkg::*;
	import fpu_exp_pkg::*;

	stage_ctl_t s1_ctl;
	stage_ctl_t s2_ctl;
	stage_ctl_t s3_ctl;
	align_t     align;	// stage 1 -> 2
	wexp_t      adj_exp;	// stage 2 -> 3

	fpu_add_exp_ctl u_ctl (
		.rclk          (rclk),
		.i_reset       (i_reset),
		.i_valid       (i_valid),
		.i_op          (i_op),
		.o_s1_ctl      (s1_ctl),
		.o_s2_ctl      (s2_ctl),
		.o_s3_ctl      (s3_ctl),
		.o_align_valid (o_align_valid),
		.o_valid       (o_valid)
	);

	fpu_exp_cmp u_cmp (
		.rclk     (rclk),
		.i_exp_a  (i_exp_a),
		.i_exp_b  (i_exp_b),
		.i_s1_ctl (s1_ctl),
		.o_align  (align)
	);

	fpu_exp_adj u_adj (
		.rclk     (rclk),
		.i_align  (align),
		.i_s2_ctl (s2_ctl),
		.o_exp    (adj_exp)
	);

	fpu_exp_norm #(
		.SHL_W (SHL_W)
	) u_norm (
		.rclk         (rclk),
		.i_reset      (i_reset),
		.i_exp        (adj_exp),
		.i_s3_ctl     (s3_ctl),
		.i_norm_inc   (i_norm_inc),
		.i_shl_cnt    (i_shl_cnt),
		.i_round_cout (i_round_cout),
		.o_exp        (o_exp)
	);

	// alignment info straight off the stage 2 register
	assign o_swap     = align.swap;
	assign o_exp_diff = align.diff;

endmodule

// File: tb/fpu_add_exp_sva.sv
`timescale 1ns/1ps

module fpu_add_exp_sva (
	input logic rclk,
	input logic i_reset,
	input logic i_valid,
	input logic o_align_valid,
	input logic o_valid
);

	////////////////////////////////////////////////////////////
	// reset
	////////////////////////////////////////////////////////////

	// first reset edge clears the output flop
	a_reset_quiet: assert property (@(posedge rclk) i_reset |=> !o_valid)
		else $error("o_valid high while in reset");

	a_reset_exit: assert property (@(posedge rclk) $fell(i_reset) |-> !o_valid ##1 !o_valid)
		else $error("o_valid high right after reset");

	////////////////////////////////////////////////////////////
	// fixed latency
	////////////////////////////////////////////////////////////

	// issue sampled at N, align loads at N+1, seen at N+2
	a_align_lat: assert property (@(posedge rclk) disable iff (i_reset)
		i_valid |-> ##2 o_align_valid)
		else $error("o_align_valid missing one cycle after issue");

	a_align_src: assert property (@(posedge rclk) disable iff (i_reset)
		o_align_valid |-> $past(i_valid, 2))
		else $error("o_align_valid without an issue");

	// result loads at N+3
	a_out_lat: assert property (@(posedge rclk) disable iff (i_reset)
		i_valid |-> ##4 o_valid)
		else $error("o_valid missing three cycles after issue");

	a_out_src: assert property (@(posedge rclk) disable iff (i_reset)
		o_valid |-> $past(i_valid, 4))
		else $error("o_valid without an issue");

endmodule

bind fpu_add_exp fpu_add_exp_sva u_sva (
	.rclk          (rclk),
	.i_reset       (i_reset),
	.i_valid       (i_valid),
	.o_align_valid (o_align_valid),
	.o_valid       (o_valid)
);

// File: tb/tb_fpu_add_exp.sv
`timescale 1ns/1ps

module tb_fpu_add_exp;

	import fpu_op_pkg::*;
	import fpu_exp_pkg::*;

	localparam int SHL_W       = 6;
	localparam int N_ITEMS     = 400;	// stimulus cycles
	localparam int B2B_ITEMS   = 150;	// valid every cycle up to here
	localparam int N_STEPS     = N_ITEMS + 6;	// plus drain
	localparam int WATCHDOG_NS = (N_ITEMS + 20) * 10;

	// side inputs for one item
	typedef struct packed {
		logic             norm_inc;
		logic [SHL_W-1:0] shl_cnt;
		logic             round_cout;
	} side_t;

	typedef struct packed {
		logic              swap;
		logic [DIFF_W-1:0] diff;
	} align_exp_t;

	logic              rclk;
	logic              i_reset;
	logic              i_valid;
	op_t               i_op;
	exp_field_t        i_exp_a;
	exp_field_t        i_exp_b;
	logic              i_norm_inc;
	logic [SHL_W-1:0]  i_shl_cnt;
	logic              i_round_cout;
	logic              o_align_valid;
	logic              o_swap;
	logic [DIFF_W-1:0] o_exp_diff;
	logic              o_valid;
	exp_field_t        o_exp;

	integer     seed = 44;
	int         errors = 0;
	int         checks = 0;
	int         step;
	align_exp_t align_q[$];	// expected swap/diff in issue order
	exp_field_t result_q[$];	// expected o_exp in issue order
	side_t      side_mem[N_STEPS];	// by issue step
	logic       issued[N_STEPS];

	fpu_add_exp #(
		.SHL_W (SHL_W)
	) dut (
		.rclk          (rclk),
		.i_reset       (i_reset),
		.i_valid       (i_valid),
		.i_op          (i_op),
		.i_exp_a       (i_exp_a),
		.i_exp_b       (i_exp_b),
		.i_norm_inc    (i_norm_inc),
		.i_shl_cnt     (i_shl_cnt),
		.i_round_cout  (i_round_cout),
		.o_align_valid (o_align_valid),
		.o_swap        (o_swap),
		.o_exp_diff    (o_exp_diff),
		.o_valid       (o_valid),
		.o_exp         (o_exp)
	);

	initial rclk = 1'b0;
	always #5 rclk = ~rclk;

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	// a and b already masked for single
	function automatic int expect_exp(input op_t op, input int a, input int b, input side_t s);
		int e;
		int top;
		e   = 0;
		top = (op == OP_ADD_S || op == OP_DTOS) ? 255 : 2047;	// inf exponent of result
		case (op)
			OP_ADD_D, OP_ADD_S: begin
				e = (a > b) ? a : b;
				if (s.norm_inc) begin
					e = e + 1;	// fraction carry out
				end else begin
					e = e - int'(s.shl_cnt);
				end
				if (e < 0) begin
					e = 0;	// denorm flush
				end
			end
			OP_STOD: e = b + 896;
			default: begin
				e = b - 896;
				if (e < 0) begin
					e = 0;
				end else if (e > 255) begin
					e = 255;
				end
			end
		endcase
		e = e + int'(s.round_cout);
		if (e > top) begin
			e = top;
		end
		return e;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("FAIL %0t %s got %0d expected %0d", $time, name, got, want);
		end
	endtask

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	task automatic draw_exp(input op_t op, output exp_field_t e);
		integer r;
		r = $random(seed);
		case (r[5:4])
			2'd0: e = {7'b0, r[11:8]};	// small, flush with shift
			2'd1: e = {8'hff, r[10:8]};	// near inf, single too after mask
			2'd2: begin
				if (op == OP_DTOS) begin	// dtos range edges
					e = r[12] ? exp_field_t'(890 + int'(r[11:8]) % 13)
					          : exp_field_t'(1145 + int'(r[11:8]) % 13);
				end else begin
					e = r[18:8];
				end
			end
			default: e = r[18:8];
		endcase
	endtask

	task automatic issue_item(input int k);
		integer     r;
		op_t        op;
		exp_field_t a;
		exp_field_t b;
		int         am;
		int         bm;
		side_t      s;
		align_exp_t al;
		r  = $random(seed);
		op = op_t'(r[1:0]);
		draw_exp(op, a);
		draw_exp(op, b);
		r            = $random(seed);
		s.norm_inc   = r[0];
		s.shl_cnt    = r[SHL_W:1];
		s.round_cout = r[8];
		if (op == OP_ADD_S || op == OP_STOD) begin	// single in bits 7:0
			am = int'(a[7:0]);
			bm = int'(b[7:0]);
		end else begin
			am = int'(a);
			bm = int'(b);
		end
		al = '0;	// converts give zero swap/diff
		if (op == OP_ADD_D || op == OP_ADD_S) begin
			al.swap = (bm > am);
			al.diff = DIFF_W'((bm > am) ? bm - am : am - bm);
		end
		align_q.push_back(al);
		result_q.push_back(exp_field_t'(expect_exp(op, am, bm, s)));
		side_mem[k] = s;
		issued[k]   = 1'b1;
		i_valid     = 1'b1;
		i_op        = op;
		i_exp_a     = a;
		i_exp_b     = b;
	endtask

	task automatic drive_step(input int k);
		integer r;
		r = $random(seed);
		if (k < B2B_ITEMS || (k < N_ITEMS && r[1:0] != 2'b00)) begin
			issue_item(k);
		end else begin
			i_valid = 1'b0;	// idle, junk on the data
			i_op    = op_t'(r[3:2]);
			i_exp_a = r[14:4];
			i_exp_b = r[25:15];
		end
		// side inputs land on the edge where the item leaves stage 3
		if (k >= 3 && issued[k-3]) begin
			i_norm_inc   = side_mem[k-3].norm_inc;
			i_shl_cnt    = side_mem[k-3].shl_cnt;
			i_round_cout = side_mem[k-3].round_cout;
		end else begin
			r            = $random(seed);
			i_norm_inc   = r[0];
			i_shl_cnt    = r[SHL_W:1];
			i_round_cout = r[9];
		end
	endtask

	task automatic check_outputs(input int k);
		logic       want_align;
		logic       want_valid;
		align_exp_t al;
		want_align = (k >= 2) ? issued[k-2] : 1'b0;
		want_valid = (k >= 4) ? issued[k-4] : 1'b0;
		check_val("o_align_valid", 32'(o_align_valid), 32'(want_align));
		check_val("o_valid", 32'(o_valid), 32'(want_valid));
		if (want_align) begin
			al = align_q.pop_front();
			check_val("o_swap", 32'(o_swap), 32'(al.swap));
			check_val("o_exp_diff", 32'(o_exp_diff), 32'(al.diff));
		end
		if (want_valid) begin
			check_val("o_exp", 32'(o_exp), 32'(result_q.pop_front()));
		end
	endtask

	////////////////////////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////////////////////////

	initial begin
		i_reset      = 1'b1;
		i_valid      = 1'b0;
		i_op         = OP_ADD_D;
		i_exp_a      = '0;
		i_exp_b      = '0;
		i_norm_inc   = 1'b0;
		i_shl_cnt    = '0;
		i_round_cout = 1'b0;
		for (step = 0; step < N_STEPS; step++) begin
			issued[step] = 1'b0;
		end
		repeat (8) @(posedge rclk);
		#1;
		i_reset = 1'b0;
		for (step = 0; step < N_STEPS; step++) begin
			check_outputs(step);	// outputs settled since the edge
			drive_step(step);
			@(posedge rclk);
			#1;
		end
		if (align_q.size() != 0 || result_q.size() != 0) begin
			errors++;
			$display("%0d alignment and %0d result entries never came out",
				align_q.size(), result_q.size());
		end
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
		$display("Errors found");
		$finish;
	end

endmodule

// File: fpu_add_exp.f
verilog/fpu_op_pkg.sv
verilog/fpu_exp_pkg.sv
verilog/fpu_add_exp_ctl.sv
verilog/fpu_exp_cmp.sv
verilog/fpu_exp_adj.sv
verilog/fpu_exp_norm.sv
verilog/fpu_add_exp.sv
tb/fpu_add_exp_sva.sv
tb/tb_fpu_add_exp.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_fpu_add_exp
FILELIST  = fpu_add_exp.f
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only when the testbench prints its pass line
run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "No errors"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
